// ==== Makefile ====
TOOL      ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_id_stage
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, the simulator exit code alone is not trusted
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
verilog/id_pkg.sv
verilog/inst_decoder.sv
verilog/operand_bypass.sv
verilog/branch_resolve.sv
verilog/id_ex_reg.sv
verilog/id_stage.sv
dv/tb_id_stage.sv

// ==== dv/tb_id_stage.sv ====
`timescale 1ns/1ps

module tb_id_stage;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 8;

	// undefined opcode that decodes to a NOP with every field zero
	localparam logic [31:0] IDLE_INST = 32'hfc000000;
	localparam id_pkg::fwd_t NO_FWD = '0;

	// one cycle of stimulus with the responses it should produce
	typedef struct packed {
		logic [31:0]  pc;
		logic [31:0]  inst;
		logic [31:0]  r1d;
		logic [31:0]  r2d;
		id_pkg::fwd_t ex_fwd;
		id_pkg::fwd_t mem_fwd;
		logic         r1_read;
		logic [4:0]   r1_addr;
		logic         r2_read;
		logic [4:0]   r2_addr;
		logic         flag;
		logic [31:0]  target;
		logic [2:0]   alusel;
		logic [7:0]   aluop;
		logic [31:0]  op1;
		logic [31:0]  op2;
		logic [4:0]   waddr;
		logic         wreg;
		logic [31:0]  link;
	} row_t;

	logic                  clk;
	logic                  reset_i;
	logic [31:0]           pc_i;
	logic [31:0]           inst_i;
	logic [31:0]           reg1_data_i;
	logic [31:0]           reg2_data_i;
	id_pkg::fwd_t          ex_fwd_i;
	id_pkg::fwd_t          mem_fwd_i;
	logic                  reg1_read_o;
	logic                  reg2_read_o;
	logic [4:0]            reg1_addr_o;
	logic [4:0]            reg2_addr_o;
	logic                  branch_flag_o;
	logic [31:0]           branch_target_o;
	id_pkg::ex_ctrl_t      ex_o;

	row_t rows[$];

	id_stage i_id_stage (
		.clk             (clk),
		.reset_i         (reset_i),
		.pc_i            (pc_i),
		.inst_i          (inst_i),
		.reg1_data_i     (reg1_data_i),
		.reg2_data_i     (reg2_data_i),
		.ex_fwd_i        (ex_fwd_i),
		.mem_fwd_i       (mem_fwd_i),
		.reg1_read_o     (reg1_read_o),
		.reg2_read_o     (reg2_read_o),
		.reg1_addr_o     (reg1_addr_o),
		.reg2_addr_o     (reg2_addr_o),
		.branch_flag_o   (branch_flag_o),
		.branch_target_o (branch_target_o),
		.ex_o            (ex_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// instruction formats and helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sh, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [25:0] idx);
		return {op, idx};
	endfunction

	function automatic id_pkg::fwd_t fwd(input logic we, input logic [4:0] addr,
		input logic [31:0] data);
		id_pkg::fwd_t f;
		f.we   = we;
		f.addr = addr;
		f.data = data;
		return f;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("error: %s expected %h actual %h", name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic apply_row(input row_t r);
		pc_i        <= r.pc;
		inst_i      <= r.inst;
		reg1_data_i <= r.r1d;
		reg2_data_i <= r.r2d;
		ex_fwd_i    <= r.ex_fwd;
		mem_fwd_i   <= r.mem_fwd;
	endtask

	// same-cycle outputs toward the register file and fetch
	task automatic check_outputs(input row_t r);
		check_value("reg1_read_o", 32'(r.r1_read), 32'(reg1_read_o));
		check_value("reg1_addr_o", 32'(r.r1_addr), 32'(reg1_addr_o));
		check_value("reg2_read_o", 32'(r.r2_read), 32'(reg2_read_o));
		check_value("reg2_addr_o", 32'(r.r2_addr), 32'(reg2_addr_o));
		check_value("branch_flag_o", 32'(r.flag), 32'(branch_flag_o));
		check_value("branch_target_o", r.target, branch_target_o);
	endtask

	// registered view of the row decoded one cycle earlier
	task automatic check_stage_reg(input row_t r, input logic ds);
		check_value("ex_o.aluop", 32'(r.aluop), 32'(ex_o.aluop));
		check_value("ex_o.alusel", 32'(r.alusel), 32'(ex_o.alusel));
		check_value("ex_o.op1", r.op1, ex_o.op1);
		check_value("ex_o.op2", r.op2, ex_o.op2);
		check_value("ex_o.waddr", 32'(r.waddr), 32'(ex_o.waddr));
		check_value("ex_o.wreg", 32'(r.wreg), 32'(ex_o.wreg));
		check_value("ex_o.link_addr", r.link, ex_o.link_addr);
		check_value("ex_o.in_delay_slot", 32'(ds), 32'(ex_o.in_delay_slot));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////////////////////////////////////////

	task automatic build_table();
		// immediate forms write rt
		rows.push_back(row_t'{32'h00001000, enc_i(6'h0d, 5'd1, 5'd3, 16'h8001),
			32'h000000f0, 32'h0, NO_FWD, NO_FWD,
			1'b1, 5'd1, 1'b0, 5'd3, 1'b0, 32'h0, id_pkg::SEL_LOGIC,
			id_pkg::ALU_OR, 32'h000000f0, 32'h00008001, 5'd3, 1'b1, 32'h0});
		rows.push_back(row_t'{32'h00001004, enc_i(6'h0c, 5'd2, 5'd4, 16'hff00),
			32'hffffffff, 32'h0, NO_FWD, NO_FWD,
			1'b1, 5'd2, 1'b0, 5'd4, 1'b0, 32'h0, id_pkg::SEL_LOGIC,
			id_pkg::ALU_AND, 32'hffffffff, 32'h0000ff00, 5'd4, 1'b1, 32'h0});
		rows.push_back(row_t'{32'h00001008, enc_i(6'h0e, 5'd6, 5'd5, 16'ha5a5),
			32'h12345678, 32'h0, NO_FWD, NO_FWD,
			1'b1, 5'd6, 1'b0, 5'd5, 1'b0, 32'h0, id_pkg::SEL_LOGIC,
			id_pkg::ALU_XOR, 32'h12345678, 32'h0000a5a5, 5'd5, 1'b1, 32'h0});
		// lui with a pending write to r0 that must not forward
		rows.push_back(row_t'{32'h0000100c, enc_i(6'h0f, 5'd0, 5'd7, 16'hbeef),
			32'h0, 32'h0, fwd(1'b1, 5'd0, 32'hdeadbeef), NO_FWD,
			1'b1, 5'd0, 1'b0, 5'd7, 1'b0, 32'h0, id_pkg::SEL_LOGIC,
			id_pkg::ALU_OR, 32'h0, 32'hbeef0000, 5'd7, 1'b1, 32'h0});
		rows.push_back(row_t'{32'h00001010, enc_i(6'h08, 5'd1, 5'd8, 16'hfffc),
			32'h00000010, 32'h0, NO_FWD, NO_FWD,
			1'b1, 5'd1, 1'b0, 5'd8, 1'b0, 32'h0, id_pkg::SEL_ARITH,
			id_pkg::ALU_ADDI, 32'h00000010, 32'hfffffffc, 5'd8, 1'b1, 32'h0});
		rows.push_back(row_t'{32'h00001014, enc_i(6'h0a, 5'd2, 5'd9, 16'h8000),
			32'h00000005, 32'h0, NO_FWD, NO_FWD,
			1'b1, 5'd2, 1'b0, 5'd9, 1'b0, 32'h0, id_pkg::SEL_ARITH,
			id_pkg::ALU_SLT, 32'h00000005, 32'hffff8000, 5'd9, 1'b1, 32'h0});
		// register forms write rd
		rows.push_back(row_t'{32'h00001018, enc_r(5'd1, 5'd2, 5'd10, 5'd0, 6'h21),
			32'h00000100, 32'h00000200, NO_FWD, NO_FWD,
			1'b1, 5'd1, 1'b1, 5'd2, 1'b0, 32'h0, id_pkg::SEL_ARITH,
			id_pkg::ALU_ADDU, 32'h00000100, 32'h00000200, 5'd10, 1'b1, 32'h0});
		rows.push_back(row_t'{32'h0000101c, enc_r(5'd3, 5'd4, 5'd11, 5'd0, 6'h22),
			32'h00000050, 32'h00000020, NO_FWD, NO_FWD,
			1'b1, 5'd3, 1'b1, 5'd4, 1'b0, 32'h0, id_pkg::SEL_ARITH,
			id_pkg::ALU_SUB, 32'h00000050, 32'h00000020, 5'd11, 1'b1, 32'h0});
		// shift amount lands in op1
		rows.push_back(row_t'{32'h00001020, enc_r(5'd0, 5'd5, 5'd12, 5'd7, 6'h00),
			32'h77777777, 32'h00000003, NO_FWD, NO_FWD,
			1'b0, 5'd0, 1'b1, 5'd5, 1'b0, 32'h0, id_pkg::SEL_SHIFT,
			id_pkg::ALU_SLL, 32'h00000007, 32'h00000003, 5'd12, 1'b1, 32'h0});
		rows.push_back(row_t'{32'h00001024, enc_i(6'h3f, 5'd2, 5'd3, 16'h0034),
			32'h22222222, 32'h33333333, fwd(1'b1, 5'd2, 32'h12121212), NO_FWD,
			1'b0, 5'd2, 1'b0, 5'd3, 1'b0, 32'h0, id_pkg::SEL_NOP,
			id_pkg::ALU_NOP, 32'h0, 32'h0, 5'd0, 1'b0, 32'h0});

		// forwarding priority
		rows.push_back(row_t'{32'h00001028, enc_r(5'd6, 5'd7, 5'd13, 5'd0, 6'h21),
			32'h00000066, 32'h00000077,
			fwd(1'b1, 5'd6, 32'haaaa0006), fwd(1'b1, 5'd6, 32'hbbbb0006),
			1'b1, 5'd6, 1'b1, 5'd7, 1'b0, 32'h0, id_pkg::SEL_ARITH,
			id_pkg::ALU_ADDU, 32'haaaa0006, 32'h00000077, 5'd13, 1'b1, 32'h0});
		rows.push_back(row_t'{32'h0000102c, enc_r(5'd6, 5'd7, 5'd13, 5'd0, 6'h21),
			32'h00000066, 32'h00000077,
			fwd(1'b1, 5'd9, 32'haaaa0009), fwd(1'b1, 5'd7, 32'hbbbb0007),
			1'b1, 5'd6, 1'b1, 5'd7, 1'b0, 32'h0, id_pkg::SEL_ARITH,
			id_pkg::ALU_ADDU, 32'h00000066, 32'hbbbb0007, 5'd13, 1'b1, 32'h0});
		rows.push_back(row_t'{32'h00001030, enc_r(5'd6, 5'd7, 5'd13, 5'd0, 6'h21),
			32'h00000066, 32'h00000077,
			fwd(1'b0, 5'd6, 32'hcccc0006), fwd(1'b0, 5'd7, 32'hdddd0007),
			1'b1, 5'd6, 1'b1, 5'd7, 1'b0, 32'h0, id_pkg::SEL_ARITH,
			id_pkg::ALU_ADDU, 32'h00000066, 32'h00000077, 5'd13, 1'b1, 32'h0});
		rows.push_back(row_t'{32'h00001034, enc_r(5'd0, 5'd7, 5'd14, 5'd0, 6'h21),
			32'h0, 32'h00000077,
			fwd(1'b1, 5'd0, 32'haaaa0000), fwd(1'b1, 5'd0, 32'hbbbb0000),
			1'b1, 5'd0, 1'b1, 5'd7, 1'b0, 32'h0, id_pkg::SEL_ARITH,
			id_pkg::ALU_ADDU, 32'h0, 32'h00000077, 5'd14, 1'b1, 32'h0});

		// beq and bne, then the delay slot after a taken branch
		rows.push_back(row_t'{32'h00002000, enc_i(6'h04, 5'd1, 5'd2, 16'h0010),
			32'h00005555, 32'h00005555, NO_FWD, NO_FWD,
			1'b1, 5'd1, 1'b1, 5'd2, 1'b1, 32'h00002044, id_pkg::SEL_JUMP_BRANCH,
			id_pkg::ALU_BEQ, 32'h00005555, 32'h00005555, 5'd0, 1'b0, 32'h0});
		rows.push_back(row_t'{32'h00002004, enc_i(6'h0d, 5'd0, 5'd3, 16'h0001),
			32'h0, 32'h0, NO_FWD, NO_FWD,
			1'b1, 5'd0, 1'b0, 5'd3, 1'b0, 32'h0, id_pkg::SEL_LOGIC,
			id_pkg::ALU_OR, 32'h0, 32'h00000001, 5'd3, 1'b1, 32'h0});
		rows.push_back(row_t'{32'h00003000, enc_i(6'h04, 5'd1, 5'd2, 16'hfff0),
			32'h00005555, 32'h00005556, NO_FWD, NO_FWD,
			1'b1, 5'd1, 1'b1, 5'd2, 1'b0, 32'h0, id_pkg::SEL_JUMP_BRANCH,
			id_pkg::ALU_BEQ, 32'h00005555, 32'h00005556, 5'd31, 1'b0, 32'h0});
		rows.push_back(row_t'{32'h00003004, enc_i(6'h05, 5'd1, 5'd2, 16'hfff0),
			32'h00005555, 32'h00005556, NO_FWD, NO_FWD,
			1'b1, 5'd1, 1'b1, 5'd2, 1'b1, 32'h00002fc8, id_pkg::SEL_JUMP_BRANCH,
			id_pkg::ALU_BNE, 32'h00005555, 32'h00005556, 5'd31, 1'b0, 32'h0});
		rows.push_back(row_t'{32'h00003008, enc_i(6'h05, 5'd1, 5'd2, 16'h0010),
			32'h00000001, 32'h00000001, NO_FWD, NO_FWD,
			1'b1, 5'd1, 1'b1, 5'd2, 1'b0, 32'h0, id_pkg::SEL_JUMP_BRANCH,
			id_pkg::ALU_BNE, 32'h00000001, 32'h00000001, 5'd0, 1'b0, 32'h0});

		// bgtz and blez on zero, positive and negative
		rows.push_back(row_t'{32'h00004000, enc_i(6'h07, 5'd4, 5'd0, 16'h0008),
			32'h0, 32'h0, NO_FWD, NO_FWD,
			1'b1, 5'd4, 1'b0, 5'd0, 1'b0, 32'h0, id_pkg::SEL_JUMP_BRANCH,
			id_pkg::ALU_BGTZ, 32'h0, 32'h0, 5'd0, 1'b0, 32'h0});
		rows.push_back(row_t'{32'h00004004, enc_i(6'h07, 5'd4, 5'd0, 16'h0008),
			32'h00000001, 32'h0, NO_FWD, NO_FWD,
			1'b1, 5'd4, 1'b0, 5'd0, 1'b1, 32'h00004028, id_pkg::SEL_JUMP_BRANCH,
			id_pkg::ALU_BGTZ, 32'h00000001, 32'h0, 5'd0, 1'b0, 32'h0});
		rows.push_back(row_t'{32'h00004008, enc_i(6'h07, 5'd4, 5'd0, 16'h0008),
			32'h80000000, 32'h0, NO_FWD, NO_FWD,
			1'b1, 5'd4, 1'b0, 5'd0, 1'b0, 32'h0, id_pkg::SEL_JUMP_BRANCH,
			id_pkg::ALU_BGTZ, 32'h80000000, 32'h0, 5'd0, 1'b0, 32'h0});
		rows.push_back(row_t'{32'h00005000, enc_i(6'h06, 5'd4, 5'd0, 16'h0008),
			32'h0, 32'h0, NO_FWD, NO_FWD,
			1'b1, 5'd4, 1'b0, 5'd0, 1'b1, 32'h00005024, id_pkg::SEL_JUMP_BRANCH,
			id_pkg::ALU_BLEZ, 32'h0, 32'h0, 5'd0, 1'b0, 32'h0});
		rows.push_back(row_t'{32'h00005004, enc_i(6'h06, 5'd4, 5'd0, 16'h0008),
			32'h7fffffff, 32'h0, NO_FWD, NO_FWD,
			1'b1, 5'd4, 1'b0, 5'd0, 1'b0, 32'h0, id_pkg::SEL_JUMP_BRANCH,
			id_pkg::ALU_BLEZ, 32'h7fffffff, 32'h0, 5'd0, 1'b0, 32'h0});
		rows.push_back(row_t'{32'h00005008, enc_i(6'h06, 5'd4, 5'd0, 16'h0008),
			32'hffffffff, 32'h0, NO_FWD, NO_FWD,
			1'b1, 5'd4, 1'b0, 5'd0, 1'b1, 32'h0000502c, id_pkg::SEL_JUMP_BRANCH,
			id_pkg::ALU_BLEZ, 32'hffffffff, 32'h0, 5'd0, 1'b0, 32'h0});

		// the linking regimm forms write r31 even when not taken
		rows.push_back(row_t'{32'h00006000, enc_i(6'h01, 5'd5, 5'h01, 16'h0004),
			32'h0, 32'h0, NO_FWD, NO_FWD,
			1'b1, 5'd5, 1'b0, 5'h01, 1'b1, 32'h00006014, id_pkg::SEL_JUMP_BRANCH,
			id_pkg::ALU_BGEZ, 32'h0, 32'h0, 5'd0, 1'b0, 32'h0});
		rows.push_back(row_t'{32'h00006004, enc_i(6'h01, 5'd5, 5'h01, 16'h0004),
			32'h80000001, 32'h0, NO_FWD, NO_FWD,
			1'b1, 5'd5, 1'b0, 5'h01, 1'b0, 32'h0, id_pkg::SEL_JUMP_BRANCH,
			id_pkg::ALU_BGEZ, 32'h80000001, 32'h0, 5'd0, 1'b0, 32'h0});
		rows.push_back(row_t'{32'h00006008, enc_i(6'h01, 5'd5, 5'h00, 16'h0004),
			32'hfffffffe, 32'h0, NO_FWD, NO_FWD,
			1'b1, 5'd5, 1'b0, 5'h00, 1'b1, 32'h0000601c, id_pkg::SEL_JUMP_BRANCH,
			id_pkg::ALU_BLTZ, 32'hfffffffe, 32'h0, 5'd0, 1'b0, 32'h0});
		rows.push_back(row_t'{32'h0000600c, enc_i(6'h01, 5'd5, 5'h00, 16'h0004),
			32'h00000002, 32'h0, NO_FWD, NO_FWD,
			1'b1, 5'd5, 1'b0, 5'h00, 1'b0, 32'h0, id_pkg::SEL_JUMP_BRANCH,
			id_pkg::ALU_BLTZ, 32'h00000002, 32'h0, 5'd0, 1'b0, 32'h0});
		rows.push_back(row_t'{32'h00007000, enc_i(6'h01, 5'd5, 5'h11, 16'h0004),
			32'h80000000, 32'h0, NO_FWD, NO_FWD,
			1'b1, 5'd5, 1'b0, 5'h11, 1'b0, 32'h0, id_pkg::SEL_JUMP_BRANCH,
			id_pkg::ALU_BGEZAL, 32'h80000000, 32'h0, 5'd31, 1'b1, 32'h00007008});
		rows.push_back(row_t'{32'h00007004, enc_i(6'h01, 5'd5, 5'h10, 16'h0004),
			32'h00000003, 32'h0, NO_FWD, NO_FWD,
			1'b1, 5'd5, 1'b0, 5'h10, 1'b0, 32'h0, id_pkg::SEL_JUMP_BRANCH,
			id_pkg::ALU_BLTZAL, 32'h00000003, 32'h0, 5'd31, 1'b1, 32'h0000700c});

		// the jump index target keeps the top bits of pc plus 4
		rows.push_back(row_t'{32'h8ffffffc, enc_j(6'h02, 26'h0000100),
			32'h0, 32'h0, NO_FWD, NO_FWD,
			1'b0, 5'd0, 1'b0, 5'd0, 1'b1, 32'h90000400, id_pkg::SEL_JUMP_BRANCH,
			id_pkg::ALU_J, 32'h0, 32'h0, 5'd0, 1'b0, 32'h0});
		rows.push_back(row_t'{32'h00008000, enc_j(6'h03, 26'h0000040),
			32'h0, 32'h0, NO_FWD, NO_FWD,
			1'b0, 5'd0, 1'b0, 5'd0, 1'b1, 32'h00000100, id_pkg::SEL_JUMP_BRANCH,
			id_pkg::ALU_JAL, 32'h0, 32'h0, 5'd31, 1'b1, 32'h00008008});
		rows.push_back(row_t'{32'h00008100, enc_r(5'd6, 5'd0, 5'd0, 5'd0, 6'h08),
			32'h00000001, 32'h0, fwd(1'b1, 5'd6, 32'h0000a000), NO_FWD,
			1'b1, 5'd6, 1'b0, 5'd0, 1'b1, 32'h0000a000, id_pkg::SEL_JUMP_BRANCH,
			id_pkg::ALU_JR, 32'h0000a000, 32'h0, 5'd0, 1'b0, 32'h0});
		rows.push_back(row_t'{32'h00008200, enc_r(5'd7, 5'd0, 5'd31, 5'd0, 6'h09),
			32'h00000001, 32'h0, NO_FWD, fwd(1'b1, 5'd7, 32'h0000b000),
			1'b1, 5'd7, 1'b0, 5'd0, 1'b1, 32'h0000b000, id_pkg::SEL_JUMP_BRANCH,
			id_pkg::ALU_JALR, 32'h0000b000, 32'h0, 5'd31, 1'b1, 32'h00008208});
	endtask

	////////////////////////////////////////////////////////////////////////////
	// sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin
		row_t prev_row;
		row_t idle_row;
		logic prev_ds;
		reset_i     = 1'b1;
		pc_i        = '0;
		inst_i      = IDLE_INST;
		reg1_data_i = '0;
		reg2_data_i = '0;
		ex_fwd_i    = NO_FWD;
		mem_fwd_i   = NO_FWD;
		build_table();

		repeat (RESET_CYCLES) @(posedge clk);
		reset_i <= 1'b0;
		@(negedge clk);
		prev_row = '0;
		prev_ds  = 1'b0;
		idle_row = '0;
		idle_row.inst = IDLE_INST;
		check_value("branch_flag_o", 32'h0, 32'(branch_flag_o));
		check_stage_reg(prev_row, prev_ds);

		// ex_o always shows the row before, flagged by the one before that
		for (int i = 0; i < rows.size(); i++) begin
			@(posedge clk);
			apply_row(rows[i]);
			@(negedge clk);
			check_outputs(rows[i]);
			check_stage_reg(prev_row, prev_ds);
			prev_ds  = prev_row.flag;
			prev_row = rows[i];
		end

		@(posedge clk);
		apply_row(idle_row);
		@(negedge clk);
		check_stage_reg(prev_row, prev_ds);

		$display("STATUS: PASS");
		$finish;
	end

	initial begin
		wait (rows.size() != 0);
		#((rows.size() + RESET_CYCLES + 20) * CLK_PERIOD);
		$display("watchdog: simulation did not reach the end of the table in time");
		$display("STATUS: FAIL");
		$fatal(1, "timeout");
	end

endmodule

// ==== verilog/branch_resolve.sv ====
`timescale 1ns/1ps

module branch_resolve (
	input  logic [id_pkg::WORD_W-1:0] pc_i,
	input  logic [31:0]               inst_i,
	input  id_pkg::br_kind_t          br_kind_i,
	input  logic                      link_i,
	input  logic [id_pkg::WORD_W-1:0] op1_i,
	input  logic [id_pkg::WORD_W-1:0] op2_i,
	output logic                      branch_flag_o,
	output logic [id_pkg::WORD_W-1:0] branch_target_o,
	output logic [id_pkg::WORD_W-1:0] link_addr_o
);

	logic [id_pkg::WORD_W-1:0] pc_plus_4;
	logic [id_pkg::WORD_W-1:0] pc_plus_8;
	logic [id_pkg::WORD_W-1:0] offset;
	logic [id_pkg::WORD_W-1:0] rel_target;
	logic [id_pkg::WORD_W-1:0] index_target;
	logic                      op1_neg;
	logic                      op1_zero;

	assign pc_plus_4 = pc_i + id_pkg::WORD_W'(4);
	assign pc_plus_8 = pc_i + id_pkg::WORD_W'(8);

	// word offset, sign extended and scaled to bytes
	assign offset       = {{(id_pkg::WORD_W-18){inst_i[15]}}, inst_i[15:0], 2'b00};
	assign rel_target   = pc_plus_4 + offset;
	// region of the delay slot keeps its top four bits
	assign index_target = {pc_plus_4[id_pkg::WORD_W-1 -: 4], inst_i[25:0], 2'b00};

	assign op1_neg  = op1_i[id_pkg::WORD_W-1];
	assign op1_zero = (op1_i == '0);

	always_comb begin
		case (br_kind_i)
			id_pkg::BR_J, id_pkg::BR_JR: branch_flag_o = 1'b1;
			id_pkg::BR_BEQ:  branch_flag_o = (op1_i == op2_i);
			id_pkg::BR_BNE:  branch_flag_o = (op1_i != op2_i);
			id_pkg::BR_BGTZ: branch_flag_o = !op1_neg && !op1_zero;
			id_pkg::BR_BLEZ: branch_flag_o = op1_neg || op1_zero;
			id_pkg::BR_BGEZ: branch_flag_o = !op1_neg;
			id_pkg::BR_BLTZ: branch_flag_o = op1_neg;
			default:         branch_flag_o = 1'b0;
		endcase
	end

	// target stays zero unless the branch goes
	always_comb begin
		if (!branch_flag_o)
			branch_target_o = '0;
		else if (br_kind_i == id_pkg::BR_J)
			branch_target_o = index_target;
		else if (br_kind_i == id_pkg::BR_JR)
			branch_target_o = op1_i;
		else
			branch_target_o = rel_target;
	end

	// return past the delay slot
	assign link_addr_o = link_i ? pc_plus_8 : '0;

endmodule

// ==== verilog/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg (
	input  logic             clk,
	input  logic             reset_i,
	input  id_pkg::ex_ctrl_t ex_d_i,
	input  logic             branch_flag_i,
	output logic             in_delay_slot_o,
	output id_pkg::ex_ctrl_t ex_o
);

	////////////////////////////////////////////////////////////////////////////
	// pipeline register toward execute
	////////////////////////////////////////////////////////////////////////////

	// cleared to a NOP that writes nothing
	always_ff @(posedge clk) begin
		if (reset_i) begin
			ex_o <= '0;
		end else begin
			ex_o <= ex_d_i;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// delay slot tracking
	////////////////////////////////////////////////////////////////////////////

	// a taken branch this cycle marks the next decoded instruction
	always_ff @(posedge clk) begin
		if (reset_i) begin
			in_delay_slot_o <= 1'b0;
		end else begin
			in_delay_slot_o <= branch_flag_i;
		end
	end

endmodule

// ==== verilog/id_pkg.sv ====
package id_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////////////

	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 5;

	// return address register for JAL and the linking branches
	localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;

	////////////////////////////////////////////////////////////////////////////
	// encodings toward execute
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [7:0] {
		ALU_NOP    = 8'h00,
		ALU_OR     = 8'h25,
		ALU_AND    = 8'h24,
		ALU_XOR    = 8'h26,
		ALU_NOR    = 8'h27,
		ALU_SLL    = 8'h7c,
		ALU_SRL    = 8'h02,
		ALU_SRA    = 8'h03,
		ALU_SLT    = 8'h2a,
		ALU_SLTU   = 8'h2b,
		ALU_ADD    = 8'h20,
		ALU_ADDU   = 8'h21,
		ALU_ADDI   = 8'h55,
		ALU_ADDIU  = 8'h56,
		ALU_SUB    = 8'h22,
		ALU_SUBU   = 8'h23,
		ALU_J      = 8'h4f,
		ALU_JAL    = 8'h50,
		ALU_JR     = 8'h08,
		ALU_JALR   = 8'h09,
		ALU_BEQ    = 8'h51,
		ALU_BNE    = 8'h52,
		ALU_BGTZ   = 8'h54,
		ALU_BLEZ   = 8'h53,
		ALU_BGEZ   = 8'h41,
		ALU_BGEZAL = 8'h4b,
		ALU_BLTZ   = 8'h40,
		ALU_BLTZAL = 8'h4a
	} aluop_t;

	// result class picks which execute unit drives the writeback value
	typedef enum logic [2:0] {
		SEL_NOP         = 3'b000,
		SEL_LOGIC       = 3'b001,
		SEL_SHIFT       = 3'b010,
		SEL_ARITH       = 3'b100,
		SEL_JUMP_BRANCH = 3'b110
	} alusel_t;

	typedef enum logic [3:0] {
		BR_NONE = 4'd0,
		BR_J    = 4'd1,
		BR_JR   = 4'd2,
		BR_BEQ  = 4'd3,
		BR_BNE  = 4'd4,
		BR_BGTZ = 4'd5,
		BR_BLEZ = 4'd6,
		BR_BGEZ = 4'd7,
		BR_BLTZ = 4'd8
	} br_kind_t;

	////////////////////////////////////////////////////////////////////////////
	// instruction field codes
	////////////////////////////////////////////////////////////////////////////

	// opcode, bits 31:26
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_REGIMM  = 6'h01;
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_JAL     = 6'h03;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_BLEZ    = 6'h06;
	localparam logic [5:0] OP_BGTZ    = 6'h07;
	localparam logic [5:0] OP_ADDI    = 6'h08;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_SLTI    = 6'h0a;
	localparam logic [5:0] OP_SLTIU   = 6'h0b;
	localparam logic [5:0] OP_ANDI    = 6'h0c;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_XORI    = 6'h0e;
	localparam logic [5:0] OP_LUI     = 6'h0f;

	// function field of SPECIAL, bits 5:0
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_SRL  = 6'h02;
	localparam logic [5:0] FN_SRA  = 6'h03;
	localparam logic [5:0] FN_SLLV = 6'h04;
	localparam logic [5:0] FN_SRLV = 6'h06;
	localparam logic [5:0] FN_SRAV = 6'h07;
	localparam logic [5:0] FN_JR   = 6'h08;
	localparam logic [5:0] FN_JALR = 6'h09;
	localparam logic [5:0] FN_ADD  = 6'h20;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUB  = 6'h22;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_SLT  = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

	// rt field of REGIMM, bits 20:16
	localparam logic [4:0] RT_BLTZ   = 5'h00;
	localparam logic [4:0] RT_BGEZ   = 5'h01;
	localparam logic [4:0] RT_BLTZAL = 5'h10;
	localparam logic [4:0] RT_BGEZAL = 5'h11;

	////////////////////////////////////////////////////////////////////////////
	// stage structs
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		aluop_t                aluop;
		alusel_t               alusel;
		logic                  reg1_read;
		logic [REG_ADDR_W-1:0] reg1_addr;
		logic                  reg2_read;
		logic [REG_ADDR_W-1:0] reg2_addr;
		logic [REG_ADDR_W-1:0] waddr;
		logic                  wreg;
		logic [WORD_W-1:0]     imm;
		br_kind_t              br_kind;
		// a return address is written to waddr
		logic                  link;
	} dec_ctrl_t;

	// writeback of a later stage, seen by decode for forwarding
	typedef struct packed {
		logic                  we;
		logic [REG_ADDR_W-1:0] addr;
		logic [WORD_W-1:0]     data;
	} fwd_t;

	typedef struct packed {
		aluop_t                aluop;
		alusel_t               alusel;
		logic [WORD_W-1:0]     op1;
		logic [WORD_W-1:0]     op2;
		logic [REG_ADDR_W-1:0] waddr;
		logic                  wreg;
		logic [WORD_W-1:0]     link_addr;
		logic                  in_delay_slot;
	} ex_ctrl_t;

endpackage

// ==== verilog/id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
	input  logic                          clk,
	input  logic                          reset_i,
	input  logic [id_pkg::WORD_W-1:0]     pc_i,
	input  logic [31:0]                   inst_i,
	input  logic [id_pkg::WORD_W-1:0]     reg1_data_i,
	input  logic [id_pkg::WORD_W-1:0]     reg2_data_i,
	input  id_pkg::fwd_t                  ex_fwd_i,
	input  id_pkg::fwd_t                  mem_fwd_i,
	output logic                          reg1_read_o,
	output logic                          reg2_read_o,
	output logic [id_pkg::REG_ADDR_W-1:0] reg1_addr_o,
	output logic [id_pkg::REG_ADDR_W-1:0] reg2_addr_o,
	output logic                          branch_flag_o,
	output logic [id_pkg::WORD_W-1:0]     branch_target_o,
	output id_pkg::ex_ctrl_t              ex_o
);

	id_pkg::dec_ctrl_t         dec;
	id_pkg::ex_ctrl_t          ex_d;
	logic [id_pkg::WORD_W-1:0] op1;
	logic [id_pkg::WORD_W-1:0] op2;
	logic [id_pkg::WORD_W-1:0] link_addr;
	logic                      in_delay_slot;

	inst_decoder i_inst_decoder (
		.inst_i (inst_i),
		.ctrl_o (dec)
	);

	// register file requests leave in the same cycle
	assign reg1_read_o = dec.reg1_read;
	assign reg1_addr_o = dec.reg1_addr;
	assign reg2_read_o = dec.reg2_read;
	assign reg2_addr_o = dec.reg2_addr;

	operand_bypass i_op1_bypass (
		.read_i     (dec.reg1_read),
		.addr_i     (dec.reg1_addr),
		.reg_data_i (reg1_data_i),
		.imm_i      (dec.imm),
		.ex_fwd_i   (ex_fwd_i),
		.mem_fwd_i  (mem_fwd_i),
		.operand_o  (op1)
	);

	operand_bypass i_op2_bypass (
		.read_i     (dec.reg2_read),
		.addr_i     (dec.reg2_addr),
		.reg_data_i (reg2_data_i),
		.imm_i      (dec.imm),
		.ex_fwd_i   (ex_fwd_i),
		.mem_fwd_i  (mem_fwd_i),
		.operand_o  (op2)
	);

	// resolved on forwarded operands, no extra bubble
	branch_resolve i_branch_resolve (
		.pc_i            (pc_i),
		.inst_i          (inst_i),
		.br_kind_i       (dec.br_kind),
		.link_i          (dec.link),
		.op1_i           (op1),
		.op2_i           (op2),
		.branch_flag_o   (branch_flag_o),
		.branch_target_o (branch_target_o),
		.link_addr_o     (link_addr)
	);

	always_comb begin
		ex_d.aluop         = dec.aluop;
		ex_d.alusel        = dec.alusel;
		ex_d.op1           = op1;
		ex_d.op2           = op2;
		ex_d.waddr         = dec.waddr;
		ex_d.wreg          = dec.wreg;
		ex_d.link_addr     = link_addr;
		ex_d.in_delay_slot = in_delay_slot;
	end

	id_ex_reg i_id_ex_reg (
		.clk             (clk),
		.reset_i         (reset_i),
		.ex_d_i          (ex_d),
		.branch_flag_i   (branch_flag_o),
		.in_delay_slot_o (in_delay_slot),
		.ex_o            (ex_o)
	);

endmodule

// ==== verilog/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
	input  logic [31:0]       inst_i,
	output id_pkg::dec_ctrl_t ctrl_o
);

	logic [5:0]                    opcode;
	logic [5:0]                    funct;
	logic [id_pkg::REG_ADDR_W-1:0] rs;
	logic [id_pkg::REG_ADDR_W-1:0] rt;
	logic [id_pkg::REG_ADDR_W-1:0] rd;
	logic [4:0]                    shamt;
	logic [15:0]                   imm16;

	assign opcode = inst_i[31:26];
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];
	assign shamt  = inst_i[10:6];
	assign funct  = inst_i[5:0];
	assign imm16  = inst_i[15:0];

	// operation for every kept SPECIAL function code
	function automatic id_pkg::aluop_t funct_aluop(input logic [5:0] f);
		case (f)
			id_pkg::FN_AND:  return id_pkg::ALU_AND;
			id_pkg::FN_OR:   return id_pkg::ALU_OR;
			id_pkg::FN_XOR:  return id_pkg::ALU_XOR;
			id_pkg::FN_NOR:  return id_pkg::ALU_NOR;
			id_pkg::FN_SLL, id_pkg::FN_SLLV: return id_pkg::ALU_SLL;
			id_pkg::FN_SRL, id_pkg::FN_SRLV: return id_pkg::ALU_SRL;
			id_pkg::FN_SRA, id_pkg::FN_SRAV: return id_pkg::ALU_SRA;
			id_pkg::FN_SLT:  return id_pkg::ALU_SLT;
			id_pkg::FN_SLTU: return id_pkg::ALU_SLTU;
			id_pkg::FN_ADD:  return id_pkg::ALU_ADD;
			id_pkg::FN_ADDU: return id_pkg::ALU_ADDU;
			id_pkg::FN_SUB:  return id_pkg::ALU_SUB;
			id_pkg::FN_SUBU: return id_pkg::ALU_SUBU;
			id_pkg::FN_JR:   return id_pkg::ALU_JR;
			id_pkg::FN_JALR: return id_pkg::ALU_JALR;
			default:         return id_pkg::ALU_NOP;
		endcase
	endfunction

	always_comb begin
		// start from a NOP, fields default to the usual R-type slots
		ctrl_o           = '0;
		ctrl_o.reg1_addr = rs;
		ctrl_o.reg2_addr = rt;
		ctrl_o.waddr     = rd;

		case (opcode)
			id_pkg::OP_SPECIAL: begin
				case (funct)
					id_pkg::FN_AND, id_pkg::FN_OR, id_pkg::FN_XOR, id_pkg::FN_NOR,
					id_pkg::FN_SLLV, id_pkg::FN_SRLV, id_pkg::FN_SRAV,
					id_pkg::FN_SLT, id_pkg::FN_SLTU, id_pkg::FN_ADD, id_pkg::FN_ADDU,
					id_pkg::FN_SUB, id_pkg::FN_SUBU: begin
						if (shamt == '0) begin
							ctrl_o.aluop     = funct_aluop(funct);
							ctrl_o.reg1_read = 1'b1;
							ctrl_o.reg2_read = 1'b1;
							ctrl_o.wreg      = 1'b1;
							if (funct[5:2] == 4'b1001)
								ctrl_o.alusel = id_pkg::SEL_LOGIC;
							else if (funct[5:3] == 3'b000)
								ctrl_o.alusel = id_pkg::SEL_SHIFT;
							else
								ctrl_o.alusel = id_pkg::SEL_ARITH;
						end
					end
					id_pkg::FN_SLL, id_pkg::FN_SRL, id_pkg::FN_SRA: begin
						// shift amount comes in as op1, value to shift is rt
						if (rs == '0) begin
							ctrl_o.aluop     = funct_aluop(funct);
							ctrl_o.alusel    = id_pkg::SEL_SHIFT;
							ctrl_o.reg2_read = 1'b1;
							ctrl_o.imm[4:0]  = shamt;
							ctrl_o.wreg      = 1'b1;
						end
					end
					id_pkg::FN_JR, id_pkg::FN_JALR: begin
						if (shamt == '0) begin
							ctrl_o.aluop     = funct_aluop(funct);
							ctrl_o.alusel    = id_pkg::SEL_JUMP_BRANCH;
							ctrl_o.reg1_read = 1'b1;
							ctrl_o.br_kind   = id_pkg::BR_JR;
							ctrl_o.wreg      = (funct == id_pkg::FN_JALR);
							ctrl_o.link      = (funct == id_pkg::FN_JALR);
						end
					end
					default: begin
					end
				endcase
			end
			id_pkg::OP_REGIMM: begin
				case (rt)
					id_pkg::RT_BLTZ: begin
						ctrl_o.aluop   = id_pkg::ALU_BLTZ;
						ctrl_o.br_kind = id_pkg::BR_BLTZ;
					end
					id_pkg::RT_BGEZ: begin
						ctrl_o.aluop   = id_pkg::ALU_BGEZ;
						ctrl_o.br_kind = id_pkg::BR_BGEZ;
					end
					id_pkg::RT_BLTZAL: begin
						ctrl_o.aluop   = id_pkg::ALU_BLTZAL;
						ctrl_o.br_kind = id_pkg::BR_BLTZ;
					end
					id_pkg::RT_BGEZAL: begin
						ctrl_o.aluop   = id_pkg::ALU_BGEZAL;
						ctrl_o.br_kind = id_pkg::BR_BGEZ;
					end
					default: begin
					end
				endcase
				if (ctrl_o.br_kind != id_pkg::BR_NONE) begin
					ctrl_o.alusel    = id_pkg::SEL_JUMP_BRANCH;
					ctrl_o.reg1_read = 1'b1;
				end
				// linking forms write r31 taken or not
				if (rt == id_pkg::RT_BLTZAL || rt == id_pkg::RT_BGEZAL) begin
					ctrl_o.waddr = id_pkg::LINK_REG;
					ctrl_o.wreg  = 1'b1;
					ctrl_o.link  = 1'b1;
				end
			end
			id_pkg::OP_J, id_pkg::OP_JAL: begin
				ctrl_o.alusel  = id_pkg::SEL_JUMP_BRANCH;
				ctrl_o.br_kind = id_pkg::BR_J;
				if (opcode == id_pkg::OP_JAL) begin
					ctrl_o.aluop = id_pkg::ALU_JAL;
					ctrl_o.waddr = id_pkg::LINK_REG;
					ctrl_o.wreg  = 1'b1;
					ctrl_o.link  = 1'b1;
				end else begin
					ctrl_o.aluop = id_pkg::ALU_J;
				end
			end
			id_pkg::OP_BEQ, id_pkg::OP_BNE, id_pkg::OP_BGTZ, id_pkg::OP_BLEZ: begin
				ctrl_o.alusel    = id_pkg::SEL_JUMP_BRANCH;
				ctrl_o.reg1_read = 1'b1;
				case (opcode)
					id_pkg::OP_BEQ: begin
						ctrl_o.aluop     = id_pkg::ALU_BEQ;
						ctrl_o.br_kind   = id_pkg::BR_BEQ;
						ctrl_o.reg2_read = 1'b1;
					end
					id_pkg::OP_BNE: begin
						ctrl_o.aluop     = id_pkg::ALU_BNE;
						ctrl_o.br_kind   = id_pkg::BR_BNE;
						ctrl_o.reg2_read = 1'b1;
					end
					id_pkg::OP_BGTZ: begin
						ctrl_o.aluop   = id_pkg::ALU_BGTZ;
						ctrl_o.br_kind = id_pkg::BR_BGTZ;
					end
					default: begin
						ctrl_o.aluop   = id_pkg::ALU_BLEZ;
						ctrl_o.br_kind = id_pkg::BR_BLEZ;
					end
				endcase
			end
			id_pkg::OP_ANDI, id_pkg::OP_ORI, id_pkg::OP_XORI, id_pkg::OP_LUI,
			id_pkg::OP_SLTI, id_pkg::OP_SLTIU, id_pkg::OP_ADDI, id_pkg::OP_ADDIU: begin
				// immediate forms, rs against imm into rt
				ctrl_o.reg1_read = 1'b1;
				ctrl_o.waddr     = rt;
				ctrl_o.wreg      = 1'b1;
				ctrl_o.alusel    = id_pkg::SEL_ARITH;
				ctrl_o.imm       = {{(id_pkg::WORD_W-16){imm16[15]}}, imm16};
				case (opcode)
					id_pkg::OP_SLTI:  ctrl_o.aluop = id_pkg::ALU_SLT;
					id_pkg::OP_SLTIU: ctrl_o.aluop = id_pkg::ALU_SLTU;
					id_pkg::OP_ADDI:  ctrl_o.aluop = id_pkg::ALU_ADDI;
					id_pkg::OP_ADDIU: ctrl_o.aluop = id_pkg::ALU_ADDIU;
					default: begin
						// logic group, zero extended
						ctrl_o.alusel = id_pkg::SEL_LOGIC;
						ctrl_o.imm    = {{(id_pkg::WORD_W-16){1'b0}}, imm16};
						if (opcode == id_pkg::OP_ANDI)
							ctrl_o.aluop = id_pkg::ALU_AND;
						else if (opcode == id_pkg::OP_XORI)
							ctrl_o.aluop = id_pkg::ALU_XOR;
						else
							ctrl_o.aluop = id_pkg::ALU_OR;
					end
				endcase
				// lui is r0 OR'ed with the field moved to the upper half
				if (opcode == id_pkg::OP_LUI) begin
					ctrl_o.reg1_addr = '0;
					ctrl_o.imm       = {imm16, {(id_pkg::WORD_W-16){1'b0}}};
				end
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== verilog/operand_bypass.sv ====
`timescale 1ns/1ps

module operand_bypass (
	input  logic                          read_i,
	input  logic [id_pkg::REG_ADDR_W-1:0] addr_i,
	input  logic [id_pkg::WORD_W-1:0]     reg_data_i,
	input  logic [id_pkg::WORD_W-1:0]     imm_i,
	input  id_pkg::fwd_t                  ex_fwd_i,
	input  id_pkg::fwd_t                  mem_fwd_i,
	output logic [id_pkg::WORD_W-1:0]     operand_o
);

	logic ex_hit;
	logic mem_hit;

	// r0 is hardwired, a pending write to it never forwards
	assign ex_hit  = read_i && ex_fwd_i.we && (addr_i != '0) && (ex_fwd_i.addr == addr_i);
	assign mem_hit = read_i && mem_fwd_i.we && (addr_i != '0) && (mem_fwd_i.addr == addr_i);

	// youngest result first
	always_comb begin
		if (ex_hit)
			operand_o = ex_fwd_i.data;
		else if (mem_hit)
			operand_o = mem_fwd_i.data;
		else if (read_i)
			operand_o = reg_data_i;
		else
			operand_o = imm_i;
	end

endmodule
